// ==== bench/rv_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module rv_checker (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        run,           // halt only legal once running
  input  wire                        is_halted,
  input  wire [31:0]                 exp_latency,   // clock edges from run to is_halted
  input  wire                        check_en,      // dbg port holds a reg to compare
  input  wire rv_core_pkg::reg_idx_t dbg_reg_addr,
  input  wire [`RV_XLEN-1:0]         dbg_reg_data,
  input  logic [`RV_XLEN-1:0]        exp_regs [`RV_NREG],
  output int                         errors
);

  logic        was_halted = 1'b0;  // sticky copy of is_halted
  logic [31:0] run_cycles = '0;    // falling edges with run high and no halt yet

  // inputs change on the rising edge, so everything is sampled on the falling one
  always @(negedge clk) begin
    int found;  // mismatches this cycle
    found = 0;
    if (reset) begin
      was_halted <= 1'b0;
      run_cycles <= '0;
    end else begin
      if (check_en && dbg_reg_data !== exp_regs[dbg_reg_addr]) begin
        $display("** Error at %0d ns: x%0d reads %h, expected %h",
                 $time, dbg_reg_addr, dbg_reg_data, exp_regs[dbg_reg_addr]);
        found++;
      end
      if (!run && is_halted) begin
        $display("** Error at %0d ns: is_halted high before run", $time);
        found++;
      end
      if (was_halted && !is_halted) begin
        $display("** Error at %0d ns: is_halted dropped without reset", $time);
        found++;
      end
      if (run && !is_halted && !was_halted) begin
        run_cycles <= run_cycles + 32'd1;
      end
      if (is_halted && !was_halted && run_cycles != exp_latency) begin
        $display("** Error at %0d ns: is_halted after %0d cycles of run, expected %0d",
                 $time, run_cycles, exp_latency);
        found++;
      end
      was_halted <= was_halted || is_halted;
    end
    errors <= errors + found;
  end

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module tb_rv_core;

  localparam int imem_aw      = $clog2(`RV_IMEM_WORDS);
  localparam int halt_timeout = 500;  // cycles from run to is_halted

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  imem_we;
  logic [imem_aw-1:0]    imem_addr;
  logic [`RV_XLEN-1:0]   imem_wdata;
  logic                  run;
  rv_core_pkg::reg_idx_t dbg_reg_addr;
  logic [`RV_XLEN-1:0]   dbg_reg_data;
  logic                  is_halted;

  logic                check_en;                 // checker compares dbg port
  logic [`RV_XLEN-1:0] exp_regs [`RV_NREG];      // final values, 0 unless listed
  logic [`RV_XLEN-1:0] prog_words [int];         // program as loaded, by word index
  int                  exp_latency = 0;          // cycles from run to is_halted
  int                  errors;                   // mismatches seen by checker
  int                  fails = 0;                // timeouts and file problems
  int                  nprog = 0;                // program words loaded
  int                  seed  = 60;               // readout order only

  always #10 clk = ~clk;  // 20 ns period

  rv_core dut_i (
    .clk(clk), .reset(reset),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .run(run),
    .dbg_reg_addr(dbg_reg_addr), .dbg_reg_data(dbg_reg_data),
    .is_halted(is_halted)
  );

  rv_checker checker_i (
    .clk(clk), .reset(reset), .run(run), .is_halted(is_halted),
    .exp_latency(exp_latency),
    .check_en(check_en), .dbg_reg_addr(dbg_reg_addr), .dbg_reg_data(dbg_reg_data),
    .exp_regs(exp_regs), .errors(errors)
  );

  // P lines go straight into imem, E lines fill the expected table
  task automatic load_testdata();
    int                  fd;
    int                  n;
    int                  idx;
    string               line;
    string               kind;
    logic [`RV_XLEN-1:0] val;
    fd = $fopen("rv_core_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open rv_core_testdata.txt for reading");
      fails++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %d %h", kind, idx, val);
        if (n >= 1 && kind.getc(0) != "#") begin  // skip blanks and comments
          if (n == 3 && kind == "P" && idx >= 0 && idx < `RV_IMEM_WORDS) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= imem_aw'(idx);
            imem_wdata <= val;
            prog_words[idx] = val;
            nprog++;
          end else if (n == 3 && kind == "E" && idx >= 0 && idx < `RV_NREG) begin
            exp_regs[idx] = val;
          end else begin
            $display("malformed line in rv_core_testdata.txt: %s", line);
            fails++;
          end
        end
      end
      $fclose(fd);
      @(posedge clk);
      imem_we <= 1'b0;
    end
  endtask

  // source registers by RV32I format, ecall reads a7 for the halt check
  function automatic logic word_reads_reg(input logic [`RV_XLEN-1:0] w,
                                          input logic [4:0]          r);
    logic hit;
    case (w[6:0])
      `RV_OP_REG, `RV_OP_STORE: hit = (w[19:15] == r) || (w[24:20] == r);
      `RV_OP_IMM, `RV_OP_LOAD:  hit = (w[19:15] == r);
      `RV_OP_SYSTEM:            hit = (r == 5'd17);
      default:                  hit = 1'b0;
    endcase
    return hit;
  endfunction

  // one cycle per word up to the ecall, five more until is_halted, one per load-use pair
  task automatic predict_halt_latency();
    int                  i;
    int                  ecall_idx;
    int                  stalls;
    logic [`RV_XLEN-1:0] w;
    i         = 0;
    ecall_idx = -1;
    stalls    = 0;
    while (ecall_idx < 0 && prog_words.exists(i)) begin
      w = prog_words[i];
      if (w == `RV_XLEN'h73) begin
        ecall_idx = i;
      end else if (w[6:0] == `RV_OP_LOAD && w[14:12] == 3'd2 && w[11:7] != 5'd0 &&
                   prog_words.exists(i + 1)) begin
        if (word_reads_reg(prog_words[i + 1], w[11:7])) begin
          stalls++;  // lw result read by the very next word
        end
      end
      i++;
    end
    if (ecall_idx < 0) begin
      $display("no ecall found among the program words");
      fails++;
    end else begin
      exp_latency = ecall_idx + 5 + stalls;
    end
  endtask

  task automatic wait_for_halt(input int limit);
    int cycles;
    cycles = 0;
    while (!is_halted && cycles < limit) begin
      @(negedge clk);  // is_halted is a flop, stable here
      cycles++;
    end
    if (!is_halted) begin
      $display("timeout: is_halted still low %0d cycles after run", limit);
      fails++;
    end
  endtask

  // walk all registers through the debug port in shuffled order
  task automatic read_back_registers();
    int order [`RV_NREG];
    int j;
    int tmp;
    for (int i = 0; i < `RV_NREG; i++) order[i] = i;
    for (int i = `RV_NREG - 1; i > 0; i--) begin
      j        = int'($unsigned($random(seed)) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < `RV_NREG; k++) begin
      @(posedge clk);
      dbg_reg_addr <= rv_core_pkg::reg_idx_t'(order[k]);
      check_en     <= 1'b1;  // compared at the next falling edge
    end
    @(posedge clk);
    check_en <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    reset        = 1'b1;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    run          = 1'b0;
    dbg_reg_addr = '0;
    check_en     = 1'b0;
    for (int i = 0; i < `RV_NREG; i++) exp_regs[i] = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    read_back_registers();  // cleared file, no halt yet
    load_testdata();
    if (nprog == 0 && fails == 0) begin
      $display("no program words found in rv_core_testdata.txt");
      fails++;
    end
    if (fails == 0) begin
      predict_halt_latency();
    end

    if (fails == 0) begin
      @(posedge clk);
      run <= 1'b1;
      wait_for_halt(halt_timeout);
      read_back_registers();  // final state against E lines
    end

    $display("checks done: %0d mismatches, %0d other failures", errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module alu (
  input  wire rv_core_pkg::alu_op_t op,
  input  wire [`RV_XLEN-1:0]        a,
  input  wire [`RV_XLEN-1:0]        b,
  output logic [`RV_XLEN-1:0]       result
);

  logic [4:0] shamt;  // rv32 shift amount
  logic       lt;     // signed a < b

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      rv_core_pkg::ALU_ADD: result = a + b;
      rv_core_pkg::ALU_SUB: result = a - b;
      rv_core_pkg::ALU_AND: result = a & b;
      rv_core_pkg::ALU_OR:  result = a | b;
      rv_core_pkg::ALU_XOR: result = a ^ b;
      rv_core_pkg::ALU_SLL: result = a << shamt;
      rv_core_pkg::ALU_SRL: result = a >> shamt;  // logical
      rv_core_pkg::ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt};
      default:              result = '0;  // unused encodings
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module decoder (
  input  wire [`RV_XLEN-1:0] instr,
  output rv_core_pkg::id_ex_t ctrl,      // operand values stay zero
  output logic               is_ecall
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s  = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

  always_comb begin
    ctrl     = '0;  // default is a bubble, nothing written
    is_ecall = 1'b0;
    case (opcode)
      `RV_OP_REG: begin
        ctrl.rs1       = instr[19:15];
        ctrl.rs2       = instr[24:20];
        ctrl.rd        = instr[11:7];
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'd0}: ctrl.alu_op = rv_core_pkg::ALU_ADD;
          {7'h20, 3'd0}: ctrl.alu_op = rv_core_pkg::ALU_SUB;
          {7'h00, 3'd1}: ctrl.alu_op = rv_core_pkg::ALU_SLL;
          {7'h00, 3'd2}: ctrl.alu_op = rv_core_pkg::ALU_SLT;
          {7'h00, 3'd4}: ctrl.alu_op = rv_core_pkg::ALU_XOR;
          {7'h00, 3'd5}: ctrl.alu_op = rv_core_pkg::ALU_SRL;
          {7'h00, 3'd6}: ctrl.alu_op = rv_core_pkg::ALU_OR;
          {7'h00, 3'd7}: ctrl.alu_op = rv_core_pkg::ALU_AND;
          default:       ctrl        = '0;  // sltu, sra and others
        endcase
      end
      `RV_OP_IMM: begin
        ctrl.rs1       = instr[19:15];  // rs2 left 0, no false stalls
        ctrl.rd        = instr[11:7];
        ctrl.imm       = imm_i;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'd0:    ctrl.alu_op = rv_core_pkg::ALU_ADD;
          3'd4:    ctrl.alu_op = rv_core_pkg::ALU_XOR;
          3'd6:    ctrl.alu_op = rv_core_pkg::ALU_OR;
          3'd7:    ctrl.alu_op = rv_core_pkg::ALU_AND;
          default: ctrl        = '0;  // slti, shifts by imm etc
        endcase
      end
      `RV_OP_LOAD: begin
        if (funct3 == 3'd2) begin  // lw
          ctrl.rs1       = instr[19:15];
          ctrl.rd        = instr[11:7];
          ctrl.imm       = imm_i;
          ctrl.use_imm   = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.reg_write = 1'b1;
        end
      end
      `RV_OP_STORE: begin
        if (funct3 == 3'd2) begin  // sw
          ctrl.rs1       = instr[19:15];
          ctrl.rs2       = instr[24:20];  // store data, forwarded in ex
          ctrl.imm       = imm_s;
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      `RV_OP_SYSTEM: begin
        if (instr[31:7] == '0) begin  // ecall, ebreak excluded
          is_ecall = 1'b1;
          ctrl.rs1 = rv_core_pkg::reg_idx_t'(17);  // read a7 for halt check
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

interface fwd_if;
  rv_core_pkg::reg_idx_t mem_rd;         // dest of instr in memory stage
  logic                  mem_reg_write;
  logic [`RV_XLEN-1:0]   mem_result;     // load data already muxed in
  rv_core_pkg::reg_idx_t wb_rd;          // dest of instr in write-back
  logic                  wb_reg_write;
  logic [`RV_XLEN-1:0]   wb_data;

  modport source (output mem_rd, mem_reg_write, mem_result, wb_rd, wb_reg_write, wb_data);
  modport sink   (input  mem_rd, mem_reg_write, mem_result, wb_rd, wb_reg_write, wb_data);
endinterface

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  fwd_if.sink                         fwd,
  input  wire rv_core_pkg::reg_idx_t  ex_rs1,
  input  wire rv_core_pkg::reg_idx_t  ex_rs2,
  input  wire rv_core_pkg::reg_idx_t  id_rs1,
  input  wire rv_core_pkg::reg_idx_t  id_rs2,
  input  wire                         ex_mem_read,  // load sitting in execute
  input  wire rv_core_pkg::reg_idx_t  ex_rd,
  output rv_core_pkg::fwd_sel_t       sel_a,
  output rv_core_pkg::fwd_sel_t       sel_b,
  output logic                        stall
);

  // newest producer wins, so memory stage is checked before write-back
  function automatic rv_core_pkg::fwd_sel_t pick(input rv_core_pkg::reg_idx_t rs);
    rv_core_pkg::fwd_sel_t sel;
    sel = rv_core_pkg::FWD_RF;
    if (fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == rs) begin
      sel = rv_core_pkg::FWD_MEM;
    end else if (fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == rs) begin
      sel = rv_core_pkg::FWD_WB;
    end
    return sel;
  endfunction

  logic load_hit_rs1;
  logic load_hit_rs2;

  assign sel_a = pick(ex_rs1);
  assign sel_b = pick(ex_rs2);  // also covers sw store data

  // load data only exists in the memory stage, so a direct consumer waits one cycle
  assign load_hit_rs1 = (ex_rd == id_rs1);
  assign load_hit_rs2 = (ex_rd == id_rs2);
  assign stall = ex_mem_read && (ex_rd != '0) && (load_hit_rs1 || load_hit_rs2);

endmodule

`default_nettype wire

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic  // stage struct
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      en,      // load d, else hold
  input  wire      bubble,  // insert all-zero payload
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      q <= '0;  // zero payload clears valid and all write enables
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module reg_file (
  input  wire                        clk,
  input  wire                        reset,
  input  wire rv_core_pkg::reg_idx_t rs1,
  input  wire rv_core_pkg::reg_idx_t rs2,
  input  wire rv_core_pkg::reg_idx_t rd,
  input  wire [`RV_XLEN-1:0]         rd_data,
  input  wire                        we,
  output logic [`RV_XLEN-1:0]        rs1_data,
  output logic [`RV_XLEN-1:0]        rs2_data,
  input  wire rv_core_pkg::reg_idx_t dbg_addr,
  output logic [`RV_XLEN-1:0]        dbg_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];
  logic                wr_live;  // write that actually lands

  assign wr_live = we && (rd != '0);  // x0 hardwired

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (wr_live && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (wr_live && rd == rs2) ? rd_data : regs[rs2];
  assign dbg_data = regs[dbg_addr];  // architectural state only

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_cfg.svh"

module rv_core (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 imem_we,     // program load strobe
  input  wire [$clog2(`RV_IMEM_WORDS)-1:0]    imem_addr,   // word index
  input  wire [`RV_XLEN-1:0]                  imem_wdata,
  input  wire                                 run,         // level, gates fetch
  input  wire rv_core_pkg::reg_idx_t          dbg_reg_addr,
  output logic [`RV_XLEN-1:0]                 dbg_reg_data,
  output logic                                is_halted
);

  localparam int imem_aw = $clog2(`RV_IMEM_WORDS);
  localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
  logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
  logic [`RV_XLEN-1:0] pc_q;
  logic                fetch_en;       // fetch a valid word this cycle
  logic                fetch_stop_q;   // halting ecall passed decode
  logic                halted_q;
  logic                stall;

  rv_core_pkg::if_id_t  if_id_d, if_id_q;
  rv_core_pkg::id_ex_t  dec_ctrl, id_ex_d, id_ex_q;
  rv_core_pkg::ex_mem_t ex_mem_d, ex_mem_q;
  rv_core_pkg::mem_wb_t mem_wb_d, mem_wb_q;

  logic                  dec_is_ecall;
  logic                  id_halt;
  logic [`RV_XLEN-1:0]   rf_rs1_data, rf_rs2_data;
  logic [`RV_XLEN-1:0]   id_rs1_val;     // rs1 with ex/mem results folded in
  rv_core_pkg::fwd_sel_t sel_a, sel_b;
  logic [`RV_XLEN-1:0]   op_a, op_b, alu_b, alu_result;
  logic [`RV_XLEN-1:0]   dmem_rdata, mem_result;

  fwd_if fwd_i ();

  function automatic logic [`RV_XLEN-1:0] fwd_mux(input rv_core_pkg::fwd_sel_t sel,
                                                  input logic [`RV_XLEN-1:0] rf_val,
                                                  input logic [`RV_XLEN-1:0] mem_val,
                                                  input logic [`RV_XLEN-1:0] wb_val);
    logic [`RV_XLEN-1:0] v;
    case (sel)
      rv_core_pkg::FWD_MEM: v = mem_val;
      rv_core_pkg::FWD_WB:  v = wb_val;
      default:              v = rf_val;
    endcase
    return v;
  endfunction

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_wdata;  // loader port, any cycle
  end

  // fetch freezes once the halting ecall is seen in decode
  assign fetch_en = run && !fetch_stop_q && !id_halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= '0;
    end else if (fetch_en && !stall) begin
      pc_q <= pc_q + `RV_XLEN'(4);  // no branches, always sequential
    end
  end

  assign if_id_d.instr = imem[pc_q[2 +: imem_aw]];  // word aligned
  assign if_id_d.valid = fetch_en;

  pipe_reg #(.payload_t(rv_core_pkg::if_id_t)) if_id_reg (
    .clk(clk), .reset(reset), .en(!stall), .bubble(1'b0), .d(if_id_d), .q(if_id_q)
  );

  decoder decoder_i (
    .instr(if_id_q.instr), .ctrl(dec_ctrl), .is_ecall(dec_is_ecall)
  );

  reg_file reg_file_i (
    .clk(clk), .reset(reset),
    .rs1(dec_ctrl.rs1), .rs2(dec_ctrl.rs2),
    .rd(mem_wb_q.rd), .rd_data(mem_wb_q.wb_data), .we(mem_wb_q.reg_write),
    .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
    .dbg_addr(dbg_reg_addr), .dbg_data(dbg_reg_data)
  );

  // a7 may still be in flight when ecall decodes, newest producer last
  always_comb begin
    id_rs1_val = rf_rs1_data;
    if (ex_mem_q.reg_write && ex_mem_q.rd != '0 && ex_mem_q.rd == dec_ctrl.rs1) begin
      id_rs1_val = mem_result;
    end
    if (id_ex_q.reg_write && id_ex_q.rd != '0 && id_ex_q.rd == dec_ctrl.rs1) begin
      id_rs1_val = alu_result;  // a load here is covered by the stall
    end
  end

  assign id_halt = if_id_q.valid && dec_is_ecall && (id_rs1_val == `RV_XLEN'(10));

  always_comb begin
    id_ex_d          = dec_ctrl;
    id_ex_d.rs1_data = rf_rs1_data;
    id_ex_d.rs2_data = rf_rs2_data;
    id_ex_d.halt     = id_halt;
    if (!if_id_q.valid) id_ex_d = '0;  // fetch bubble stays a bubble
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_stop_q <= 1'b0;
    end else if (id_halt && !stall) begin
      fetch_stop_q <= 1'b1;  // sticky until reset
    end
  end

  hazard_unit hazard_unit_i (
    .fwd(fwd_i.sink),
    .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
    .id_rs1(id_ex_d.rs1), .id_rs2(id_ex_d.rs2),
    .ex_mem_read(id_ex_q.mem_read), .ex_rd(id_ex_q.rd),
    .sel_a(sel_a), .sel_b(sel_b), .stall(stall)
  );

  pipe_reg #(.payload_t(rv_core_pkg::id_ex_t)) id_ex_reg (
    .clk(clk), .reset(reset), .en(1'b1), .bubble(stall), .d(id_ex_d), .q(id_ex_q)
  );

  // execute
  assign op_a  = fwd_mux(sel_a, id_ex_q.rs1_data, fwd_i.mem_result, fwd_i.wb_data);
  assign op_b  = fwd_mux(sel_b, id_ex_q.rs2_data, fwd_i.mem_result, fwd_i.wb_data);
  assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : op_b;

  alu alu_i (
    .op(id_ex_q.alu_op), .a(op_a), .b(alu_b), .result(alu_result)
  );

  assign ex_mem_d.result     = alu_result;
  assign ex_mem_d.store_data = op_b;  // forwarded rs2
  assign ex_mem_d.rd         = id_ex_q.rd;
  assign ex_mem_d.mem_read   = id_ex_q.mem_read;
  assign ex_mem_d.mem_write  = id_ex_q.mem_write;
  assign ex_mem_d.reg_write  = id_ex_q.reg_write;
  assign ex_mem_d.halt       = id_ex_q.halt;

  pipe_reg #(.payload_t(rv_core_pkg::ex_mem_t)) ex_mem_reg (
    .clk(clk), .reset(reset), .en(1'b1), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q)
  );

  // memory stage on a single-cycle array
  always_ff @(posedge clk) begin
    if (ex_mem_q.mem_write) dmem[ex_mem_q.result[2 +: dmem_aw]] <= ex_mem_q.store_data;
  end

  assign dmem_rdata = dmem[ex_mem_q.result[2 +: dmem_aw]];
  assign mem_result = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.result;

  assign mem_wb_d.wb_data   = mem_result;
  assign mem_wb_d.rd        = ex_mem_q.rd;
  assign mem_wb_d.reg_write = ex_mem_q.reg_write;
  assign mem_wb_d.halt      = ex_mem_q.halt;

  pipe_reg #(.payload_t(rv_core_pkg::mem_wb_t)) mem_wb_reg (
    .clk(clk), .reset(reset), .en(1'b1), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
  );

  // results fed back to the forwarding logic
  assign fwd_i.mem_rd        = ex_mem_q.rd;
  assign fwd_i.mem_reg_write = ex_mem_q.reg_write;
  assign fwd_i.mem_result    = mem_result;
  assign fwd_i.wb_rd         = mem_wb_q.rd;
  assign fwd_i.wb_reg_write  = mem_wb_q.reg_write;
  assign fwd_i.wb_data       = mem_wb_q.wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      halted_q <= 1'b0;
    end else if (mem_wb_q.halt) begin
      halted_q <= 1'b1;  // ecall retired, everything ahead is done
    end
  end

  assign is_halted = halted_q;

endmodule

`default_nettype wire

// ==== logic/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define RV_XLEN       32   // data and address width
`define RV_NREG       32   // architectural registers, index width follows
`define RV_IMEM_WORDS 256  // instruction memory depth in words
`define RV_DMEM_WORDS 256  // data memory depth in words

// major opcodes of the kept RV32I subset
`define RV_OP_REG     7'b0110011  // r-type alu
`define RV_OP_IMM     7'b0010011  // i-type alu
`define RV_OP_LOAD    7'b0000011  // lw only
`define RV_OP_STORE   7'b0100011  // sw only
`define RV_OP_SYSTEM  7'b1110011  // ecall only

`endif

// ==== logic/rv_core_pkg.sv ====
`default_nettype none
`include "rv_core_cfg.svh"

package rv_core_pkg;

  typedef logic [$clog2(`RV_NREG)-1:0] reg_idx_t;  // register index

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,  // also address calc for lw/sw
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SLT = 4'd7   // signed
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,  // value latched in decode
    FWD_MEM = 2'd1,  // memory-stage result
    FWD_WB  = 2'd2   // write-back value
  } fwd_sel_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] instr;
    logic                valid;  // low for fetch bubbles
  } if_id_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm;       // sign-extended i or s immediate
    reg_idx_t            rs1;
    reg_idx_t            rs2;
    reg_idx_t            rd;
    alu_op_t             alu_op;
    logic                use_imm;   // alu b from imm
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    logic                halt;      // halting ecall
  } id_ex_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] result;      // alu out or address
    logic [`RV_XLEN-1:0] store_data;  // forwarded rs2
    reg_idx_t            rd;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    logic                halt;
  } ex_mem_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] wb_data;  // load data or alu result
    reg_idx_t            rd;
    logic                reg_write;
    logic                halt;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o tb_rv_core_sim
./obj_dir/tb_rv_core_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== rv_core.f ====
+incdir+logic
logic/rv_core_pkg.sv
logic/fwd_if.sv
logic/pipe_reg.sv
logic/decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/rv_core.sv
bench/rv_checker.sv
bench/tb_rv_core.sv

// ==== rv_core_testdata.txt ====
# P <imem word index> <instruction hex>   program word, loaded after reset
# E <register> <value hex>                expected final value, unlisted registers expect 0
P 0  00500093  # addi x1, x0, 5
P 1  ffd00113  # addi x2, x0, -3
P 2  002081b3  # add  x3, x1, x2   x2 from mem, x1 from wb
P 3  40118233  # sub  x4, x3, x1
P 4  001272b3  # and  x5, x4, x1
P 5  0022e333  # or   x6, x5, x2
P 6  001343b3  # xor  x7, x6, x1
P 7  00309433  # sll  x8, x1, x3
P 8  003154b3  # srl  x9, x2, x3
P 9  00112533  # slt  x10, x2, x1
P 10 0020a5b3  # slt  x11, x1, x2
P 11 0f017613  # andi x12, x2, 0xf0
P 12 7000e693  # ori  x13, x1, 0x700
P 13 fff0c713  # xori x14, x1, -1
P 14 00708013  # addi x0, x1, 7    dropped
P 15 001007b3  # add  x15, x0, x1
P 16 00702823  # sw   x7, 16(x0)
P 17 01002803  # lw   x16, 16(x0)
P 18 00180933  # add  x18, x16, x1  load-use stall
P 19 00a00893  # addi x17, x0, 10
P 20 00000073  # ecall              halts
P 21 00100993  # addi x19, x0, 1    must not retire
P 22 00200a13  # addi x20, x0, 2    must not retire
E 0  00000000
E 1  00000005
E 2  fffffffd
E 3  00000002
E 4  fffffffd
E 5  00000005
E 6  fffffffd
E 7  fffffff8
E 8  00000014
E 9  3fffffff
E 10 00000001
E 11 00000000
E 12 000000f0
E 13 00000705
E 14 fffffffa
E 15 00000005
E 16 fffffff8
E 17 0000000a
E 18 fffffffd
E 19 00000000
E 20 00000000
